// ==== design/eth_tx_pkg.sv ====
// ----------------------------------------------------------
// Shared constants and types for the 64-bit Ethernet
// transmitter. XGMII control characters, preamble bytes,
// CRC-32 constants and the structs that pass between the
// framer, the CRC chain and the XGMII encoder. Modules
// refer to these by scoped name.
// ----------------------------------------------------------
`default_nettype none

package eth_tx_pkg;

    // datapath geometry
    localparam int data_bytes = 8;
    localparam int lane_bits = 8;

    // xgmii control characters
    localparam logic [7:0] xgmii_idle = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hfb;
    localparam logic [7:0] xgmii_term = 8'hfd;
    localparam logic [7:0] xgmii_error = 8'hfe;

    // preamble and start of frame delimiter
    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hd5;

    // reflected form of 0x04c11db7
    localparam logic [31:0] crc_poly_rev = 32'hedb88320;
    localparam logic [31:0] crc_init = 32'hffffffff;

    // inter frame gap in characters
    localparam logic [4:0] min_ifg = 5'd12;

    typedef enum logic [2:0] {
        st_idle,
        st_payload,
        st_fcs_1,
        st_fcs_2,
        st_ifg,
        st_wait_end
    } tx_state_t;

    // one beat of the input stream, keep bit per lane
    typedef struct packed {
        logic [data_bytes*lane_bits-1:0] data;
        logic [data_bytes-1:0]           keep;
        logic                            last;
    } beat_t;

    // ctrl bit set marks a control character in that lane
    typedef struct packed {
        logic [data_bytes*lane_bits-1:0] data;
        logic [data_bytes-1:0]           ctrl;
    } xgmii_word_t;

    // word the encoder builds on the next edge
    typedef enum logic [2:0] {
        sel_idle,
        sel_start,
        sel_payload,
        sel_fcs_first,
        sel_fcs_second,
        sel_abort
    } word_sel_t;

    // ifg_offset counts the terminate and the idles in the closing word
    typedef struct packed {
        logic       extra_cycle;
        logic [3:0] ifg_offset;
    } term_info_t;

    // crc after lanes 0..k of the held beat
    typedef logic [data_bytes-1:0][31:0] crc_taps_t;

endpackage

`default_nettype wire

// ==== design/crc_byte_step.sv ====
// ----------------------------------------------------------
// One byte of the reflected CRC-32 update. Purely
// combinational, so eight of these in a row advance the CRC
// over a whole 64-bit beat in one cycle. The encoder taps
// the chain between steps to get the CRC of partial beats.
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module crc_byte_step (
    input  logic [7:0]  lane_data,
    input  logic [31:0] crc_in,
    output logic [31:0] crc_out
);

    logic [31:0] crc;

    always_comb begin
        // data enters at the low end in the reflected form
        crc = crc_in ^ 32'(lane_data);
        for (int b = 0; b < eth_tx_pkg::lane_bits; b++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ eth_tx_pkg::crc_poly_rev;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_out = crc;
    end

endmodule

`default_nettype wire

// ==== design/tx_framer.sv ====
// ----------------------------------------------------------
// Transmit state machine. Registers each accepted beat with
// unused lanes zeroed, drives the input ready, keeps the
// running CRC of all full beats and counts down the gap
// after each frame. Tells the encoder every cycle which word
// to build next.
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tx_framer (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  eth_tx_pkg::beat_t      in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output eth_tx_pkg::beat_t      held_beat,
    output logic [31:0]            crc_state,
    input  logic [31:0]            crc_final,
    input  eth_tx_pkg::term_info_t term_info,
    output eth_tx_pkg::word_sel_t  sel
);

    eth_tx_pkg::tx_state_t state;
    eth_tx_pkg::tx_state_t state_next;
    eth_tx_pkg::beat_t     masked_beat;

    logic                                accept;
    logic                                ready_next;
    logic                                clear_crc;
    logic                                load_crc;
    logic [4:0]                          ifg_count;
    logic [4:0]                          ifg_count_next;
    logic [4:0]                          ifg_after_word;
    logic [eth_tx_pkg::data_bytes-1:0]   keep_plus_one;

    assign accept = in_valid && in_ready;

    // idles still owed once this cycle's idle word is out
    assign ifg_after_word = (ifg_count > 5'd8) ? ifg_count - 5'd8 : 5'd0;

    always_comb begin
        masked_beat = in_beat;
        for (int i = 0; i < eth_tx_pkg::data_bytes; i++) begin
            if (!in_beat.keep[i]) begin
                masked_beat.data[i*eth_tx_pkg::lane_bits +: eth_tx_pkg::lane_bits] = '0;
            end
        end
    end

    always_comb begin
        state_next = state;
        ready_next = 1'b0;
        sel = eth_tx_pkg::sel_idle;
        clear_crc = 1'b0;
        load_crc = 1'b0;
        ifg_count_next = ifg_count;

        case (state)
            eth_tx_pkg::st_idle: begin
                clear_crc = 1'b1;
                ready_next = 1'b1;
                if (accept) begin
                    sel = eth_tx_pkg::sel_start;
                    // a one beat frame goes straight to the fcs
                    if (in_beat.last) begin
                        ready_next = 1'b0;
                        state_next = eth_tx_pkg::st_fcs_1;
                    end else begin
                        state_next = eth_tx_pkg::st_payload;
                    end
                end
            end
            eth_tx_pkg::st_payload: begin
                load_crc = 1'b1;
                ready_next = 1'b1;
                if (accept) begin
                    sel = eth_tx_pkg::sel_payload;
                    if (in_beat.last) begin
                        ready_next = 1'b0;
                        state_next = eth_tx_pkg::st_fcs_1;
                    end
                end else begin
                    // underrun, close the frame with errors
                    sel = eth_tx_pkg::sel_abort;
                    // abort word already carries three idles
                    ifg_count_next = eth_tx_pkg::min_ifg - 5'd3;
                    state_next = eth_tx_pkg::st_wait_end;
                end
            end
            eth_tx_pkg::st_fcs_1: begin
                sel = eth_tx_pkg::sel_fcs_first;
                // offset includes the terminate, only idles are owed here
                ifg_count_next = eth_tx_pkg::min_ifg + 5'd1 - 5'(term_info.ifg_offset);
                if (term_info.extra_cycle) begin
                    state_next = eth_tx_pkg::st_fcs_2;
                end else begin
                    state_next = eth_tx_pkg::st_ifg;
                end
            end
            eth_tx_pkg::st_fcs_2: begin
                sel = eth_tx_pkg::sel_fcs_second;
                state_next = eth_tx_pkg::st_ifg;
            end
            eth_tx_pkg::st_ifg: begin
                clear_crc = 1'b1;
                ifg_count_next = ifg_after_word;
                if (ifg_after_word == 5'd0) begin
                    ready_next = 1'b1;
                    state_next = eth_tx_pkg::st_idle;
                end
            end
            eth_tx_pkg::st_wait_end: begin
                // drain the rest of the broken frame
                ready_next = 1'b1;
                ifg_count_next = ifg_after_word;
                if (accept && in_beat.last) begin
                    if (ifg_after_word == 5'd0) begin
                        state_next = eth_tx_pkg::st_idle;
                    end else begin
                        ready_next = 1'b0;
                        state_next = eth_tx_pkg::st_ifg;
                    end
                end
            end
            default: begin
                state_next = eth_tx_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= eth_tx_pkg::st_idle;
            in_ready <= 1'b0;
            ifg_count <= 5'd0;
            crc_state <= eth_tx_pkg::crc_init;
        end else begin
            state <= state_next;
            in_ready <= ready_next;
            ifg_count <= ifg_count_next;
            if (clear_crc) begin
                crc_state <= eth_tx_pkg::crc_init;
            end else if (load_crc) begin
                crc_state <= crc_final;
            end
        end
    end

    // held until the next beat, so fcs_2 still sees the last beat
    always_ff @(posedge clk) begin
        if (accept) begin
            held_beat <= masked_beat;
        end
    end

    // contiguous keep has no set bit above a clear one
    assign keep_plus_one = in_beat.keep + 1'b1;

    assert property (@(posedge clk) disable iff (reset_crc)
        accept |-> ((in_beat.keep & keep_plus_one) == '0))
        else $error("keep not contiguous: %h", in_beat.keep);

    assert property (@(posedge clk) disable iff (reset_crc)
        (accept && in_beat.last) |-> (in_beat.keep != '0))
        else $error("empty keep on last beat");

endmodule

`default_nettype wire

// ==== design/xgmii_encoder.sv ====
// ----------------------------------------------------------
// Builds the registered XGMII word from the framer's select.
// Places the start word, payload, FCS with terminate, abort
// and idle words. Also tells the framer from the last
// beat's keep whether the FCS spills into a second word and
// how much of the gap the closing word already covers.
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module xgmii_encoder (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  eth_tx_pkg::word_sel_t   sel,
    input  eth_tx_pkg::beat_t       held_beat,
    input  eth_tx_pkg::crc_taps_t   taps,
    output eth_tx_pkg::term_info_t  term_info,
    output eth_tx_pkg::xgmii_word_t xgmii
);

    logic [2:0]                              last_idx;
    logic [3:0]                              valid_bytes;
    logic [31:0]                             fcs;
    logic [1:0]                              crc_idx;
    logic [2*eth_tx_pkg::data_bytes*8-1:0]   held_wide;
    logic [2*eth_tx_pkg::data_bytes*8-1:0]   pair_data;
    logic [2*eth_tx_pkg::data_bytes-1:0]     pair_ctrl;
    logic [eth_tx_pkg::data_bytes-1:0]       term_flags;
    eth_tx_pkg::xgmii_word_t                 word_next;

    // lane of the last valid byte
    always_comb begin
        casez (held_beat.keep)
            8'b??????01: last_idx = 3'd0;
            8'b?????011: last_idx = 3'd1;
            8'b????0111: last_idx = 3'd2;
            8'b???01111: last_idx = 3'd3;
            8'b??011111: last_idx = 3'd4;
            8'b?0111111: last_idx = 3'd5;
            8'b01111111: last_idx = 3'd6;
            default:     last_idx = 3'd7;
        endcase
    end

    assign valid_bytes = {1'b0, last_idx} + 4'd1;
    assign fcs = ~taps[last_idx];

    // four or more bytes push the terminate into a second word
    assign term_info.extra_cycle = (last_idx >= 3'd3);
    assign term_info.ifg_offset = term_info.extra_cycle ? 4'd11 - {1'b0, last_idx}
                                                        : 4'd3 - {1'b0, last_idx};

    assign held_wide = {{(eth_tx_pkg::data_bytes * 8){1'b0}}, held_beat.data};

    // data, fcs, terminate and idles laid out over two words
    always_comb begin
        pair_data = '0;
        pair_ctrl = '0;
        crc_idx = '0;
        for (int i = 0; i < 2 * eth_tx_pkg::data_bytes; i++) begin
            crc_idx = 2'(i - int'(valid_bytes));
            if (i < int'(valid_bytes)) begin
                pair_data[i*8 +: 8] = held_wide[i*8 +: 8];
            end else if (i < int'(valid_bytes) + 4) begin
                pair_data[i*8 +: 8] = fcs[crc_idx*8 +: 8];
            end else if (i == int'(valid_bytes) + 4) begin
                pair_data[i*8 +: 8] = eth_tx_pkg::xgmii_term;
                pair_ctrl[i] = 1'b1;
            end else begin
                pair_data[i*8 +: 8] = eth_tx_pkg::xgmii_idle;
                pair_ctrl[i] = 1'b1;
            end
        end
    end

    always_comb begin
        word_next.data = {eth_tx_pkg::data_bytes{eth_tx_pkg::xgmii_idle}};
        word_next.ctrl = '1;
        case (sel)
            eth_tx_pkg::sel_start: begin
                word_next.data = {eth_tx_pkg::eth_sfd, {6{eth_tx_pkg::eth_pre}},
                                  eth_tx_pkg::xgmii_start};
                word_next.ctrl = 8'h01;
            end
            eth_tx_pkg::sel_payload: begin
                word_next.data = held_beat.data;
                word_next.ctrl = '0;
            end
            eth_tx_pkg::sel_fcs_first: begin
                word_next.data = pair_data[0 +: eth_tx_pkg::data_bytes*8];
                word_next.ctrl = pair_ctrl[0 +: eth_tx_pkg::data_bytes];
            end
            eth_tx_pkg::sel_fcs_second: begin
                word_next.data = pair_data[eth_tx_pkg::data_bytes*8 +: eth_tx_pkg::data_bytes*8];
                word_next.ctrl = pair_ctrl[eth_tx_pkg::data_bytes +: eth_tx_pkg::data_bytes];
            end
            eth_tx_pkg::sel_abort: begin
                word_next.data = {{3{eth_tx_pkg::xgmii_idle}}, eth_tx_pkg::xgmii_term,
                                  {4{eth_tx_pkg::xgmii_error}}};
                word_next.ctrl = '1;
            end
            default: begin
                word_next.ctrl = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            xgmii.data <= {eth_tx_pkg::data_bytes{eth_tx_pkg::xgmii_idle}};
            xgmii.ctrl <= '1;
        end else begin
            xgmii <= word_next;
        end
    end

    always_comb begin
        for (int i = 0; i < eth_tx_pkg::data_bytes; i++) begin
            term_flags[i] = xgmii.ctrl[i] && (xgmii.data[i*8 +: 8] == eth_tx_pkg::xgmii_term);
        end
    end

    // framer select and keep decode together never yield two terminates
    assert property (@(posedge clk) disable iff (reset_crc)
        $countones(term_flags) <= 1)
        else $error("multiple terminates in word: ctrl %h", xgmii.ctrl);

endmodule

`default_nettype wire

// ==== design/eth_tx_top.sv ====
// ----------------------------------------------------------
// Top level of the 64-bit Ethernet transmitter. Takes frame
// beats on a valid/ready stream and drives registered XGMII
// words. The framer feeds a chain of eight CRC byte steps,
// and the encoder reads the chain taps to place the FCS.
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module eth_tx_top (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  eth_tx_pkg::beat_t       in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output eth_tx_pkg::xgmii_word_t xgmii
);

    eth_tx_pkg::beat_t      held_beat;
    logic [31:0]            crc_state;
    eth_tx_pkg::crc_taps_t  taps;
    eth_tx_pkg::term_info_t term_info;
    eth_tx_pkg::word_sel_t  sel;

    tx_framer u_framer (
        .clk       (clk),
        .reset_crc (reset_crc),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .held_beat (held_beat),
        .crc_state (crc_state),
        .crc_final (taps[eth_tx_pkg::data_bytes-1]),
        .term_info (term_info),
        .sel       (sel)
    );

    // one step per lane, each continuing from the previous lane
    for (genvar k = 0; k < eth_tx_pkg::data_bytes; k++) begin : g_crc
        logic [31:0] step_in;

        if (k == 0) begin : g_first
            assign step_in = crc_state;
        end else begin : g_next
            assign step_in = taps[k-1];
        end

        crc_byte_step u_step (
            .lane_data (held_beat.data[k*eth_tx_pkg::lane_bits +: eth_tx_pkg::lane_bits]),
            .crc_in    (step_in),
            .crc_out   (taps[k])
        );
    end

    xgmii_encoder u_encoder (
        .clk       (clk),
        .reset_crc (reset_crc),
        .sel       (sel),
        .held_beat (held_beat),
        .taps      (taps),
        .term_info (term_info),
        .xgmii     (xgmii)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// ----------------------------------------------------------
// Clock and reset source for the transmitter testbench.
// clk runs with an 8 ns period and reset_crc is held high
// for the first two rising edges.
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset_crc
);

    logic reset_q = 1'b1;

    assign reset_crc = reset_q;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (2) @(posedge clk);
        reset_q <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
// ----------------------------------------------------------
// Testbench for the 64-bit Ethernet transmitter. Sends
// random frames, some with a gap in valid, and follows the
// XGMII stream word by word against a model built from the
// frame bytes and a bytewise CRC-32. Concurrent assertions
// do the checking and a summary line closes the run.
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int num_frames = 20;
    localparam int max_beats = 40;
    localparam int mem_size = num_frames * max_beats * 8;
    localparam int ifg_min = 12;
    localparam logic [31:0] crc_poly = 32'hedb88320;

    localparam eth_tx_pkg::xgmii_word_t idle_word = {{8{eth_tx_pkg::xgmii_idle}}, 8'hff};
    localparam eth_tx_pkg::xgmii_word_t start_word = {eth_tx_pkg::eth_sfd,
        {6{eth_tx_pkg::eth_pre}}, eth_tx_pkg::xgmii_start, 8'h01};

    logic                    clk;
    logic                    reset_crc;
    logic                    in_valid = 1'b0;
    logic                    in_ready;
    eth_tx_pkg::beat_t       in_beat = '0;
    eth_tx_pkg::xgmii_word_t xgmii;

    // frame table, filled once at time zero
    logic [7:0]  mem [mem_size];
    int          n_beats [num_frames];
    int          n_bytes [num_frames];
    int          offset [num_frames];
    int          abort_beat [num_frames];
    logic [31:0] fcs_ref [num_frames];

    integer seed;
    int     errors = 0;
    int     cycles = 0;
    int     cycle_limit;

    int   frame_idx;
    int   beat_idx;
    logic dropped;

    logic                    in_frame;
    int                      mon_frame;
    int                      mon_word;
    int                      idle_run;
    logic                    start_seen;
    eth_tx_pkg::xgmii_word_t exp_word;

    tb_clock u_clock (
        .clk       (clk),
        .reset_crc (reset_crc)
    );

    eth_tx_top u_dut (
        .clk       (clk),
        .reset_crc (reset_crc),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .xgmii     (xgmii)
    );

    function automatic logic [31:0] crc_ref(input int start, input int count);
        logic [31:0] crc;
        crc = 32'hffffffff;
        for (int i = 0; i < count; i++) begin
            crc = crc ^ {24'h0, mem[start + i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ crc_poly) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    function automatic eth_tx_pkg::beat_t make_beat(input int f, input int b);
        eth_tx_pkg::beat_t beat;
        int                count;
        for (int i = 0; i < 8; i++) begin
            beat.data[i*8 +: 8] = mem[offset[f] + b * 8 + i];
        end
        beat.last = (b == n_beats[f] - 1);
        count = beat.last ? n_bytes[f] - b * 8 : 8;
        beat.keep = 8'((9'd1 << count) - 9'd1);
        return beat;
    endfunction

    // word w of frame f, counted from 1 after the start word
    function automatic eth_tx_pkg::xgmii_word_t expected_word(input int f, input int w);
        eth_tx_pkg::xgmii_word_t word;
        int                      pos;
        word = idle_word;
        if (f >= num_frames) begin
            return word;
        end
        if (abort_beat[f] != 0 && w == abort_beat[f]) begin
            word.data = {{3{eth_tx_pkg::xgmii_idle}}, eth_tx_pkg::xgmii_term,
                         {4{eth_tx_pkg::xgmii_error}}};
            return word;
        end
        for (int i = 0; i < 8; i++) begin
            pos = (w - 1) * 8 + i;
            if (pos < n_bytes[f]) begin
                word.data[i*8 +: 8] = mem[offset[f] + pos];
                word.ctrl[i] = 1'b0;
            end else if (pos < n_bytes[f] + 4) begin
                // fcs goes out least significant byte first
                word.data[i*8 +: 8] = fcs_ref[f][(pos - n_bytes[f])*8 +: 8];
                word.ctrl[i] = 1'b0;
            end else if (pos == n_bytes[f] + 4) begin
                word.data[i*8 +: 8] = eth_tx_pkg::xgmii_term;
            end
        end
        return word;
    endfunction

    function automatic int last_word(input int f);
        if (abort_beat[f] != 0) begin
            return abort_beat[f];
        end
        return (n_bytes[f] + 4) / 8 + 1;
    endfunction

    // idles that follow the terminate in the closing word
    function automatic int trailing_idles(input int f);
        if (abort_beat[f] != 0) begin
            return 3;
        end
        return 7 - (n_bytes[f] + 4) % 8;
    endfunction

    task automatic report_value(input string name, input logic [71:0] exp,
                                input logic [71:0] got);
        errors++;
        $display("FAILED %s exp %h got %h", name, exp, got);
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic finish_run();
        $display("summary: %0d errors over %0d frames", errors, num_frames);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin : build_frames
        int pos;
        int keep_count;
        seed = 83;
        pos = 0;
        cycle_limit = 100;
        for (int f = 0; f < num_frames; f++) begin
            n_beats[f] = 1 + int'($unsigned($random(seed)) % max_beats);
            keep_count = 1 + int'($unsigned($random(seed)) % 8);
            n_bytes[f] = (n_beats[f] - 1) * 8 + keep_count;
            offset[f] = pos;
            abort_beat[f] = 0;
            // roughly one frame in four gets a gap in valid
            if (n_beats[f] > 1 && ($random(seed) & 3) == 0) begin
                abort_beat[f] = 1 + int'($unsigned($random(seed)) % (n_beats[f] - 1));
            end
            pos += n_beats[f] * 8;
            cycle_limit += n_beats[f] + 4;
        end
        for (int a = 0; a < mem_size; a++) begin
            mem[a] = 8'($random(seed));
        end
        for (int f = 0; f < num_frames; f++) begin
            fcs_ref[f] = crc_ref(offset[f], n_bytes[f]);
        end
    end

    always @(posedge clk) begin : drive_stimulus
        int   f;
        int   b;
        logic drop;
        if (reset_crc) begin
            in_valid <= 1'b0;
            frame_idx <= 0;
            beat_idx <= 0;
            dropped <= 1'b0;
        end else if (frame_idx < num_frames) begin
            f = frame_idx;
            b = beat_idx;
            drop = dropped;
            if (in_valid && in_ready) begin
                if (b == n_beats[f] - 1) begin
                    f++;
                    b = 0;
                    drop = 1'b0;
                end else begin
                    b++;
                end
            end
            if (f >= num_frames) begin
                in_valid <= 1'b0;
            end else if (abort_beat[f] != 0 && b == abort_beat[f] && !drop) begin
                // one idle cycle mid frame, the DUT sees an underrun
                in_valid <= 1'b0;
                drop = 1'b1;
            end else begin
                in_valid <= 1'b1;
                in_beat <= make_beat(f, b);
            end
            frame_idx <= f;
            beat_idx <= b;
            dropped <= drop;
        end
    end

    assign start_seen = !in_frame && xgmii.ctrl[0] &&
                        (xgmii.data[7:0] == eth_tx_pkg::xgmii_start);

    always_comb begin
        exp_word = expected_word(mon_frame, mon_word);
    end

    // follows the xgmii stream one word at a time
    always @(posedge clk) begin
        if (reset_crc) begin
            in_frame <= 1'b0;
            mon_frame <= 0;
            mon_word <= 0;
            idle_run <= ifg_min;
        end else if (in_frame) begin
            if (mon_word == last_word(mon_frame)) begin
                in_frame <= 1'b0;
                mon_frame <= mon_frame + 1;
                idle_run <= trailing_idles(mon_frame);
            end else begin
                mon_word <= mon_word + 1;
            end
        end else if (start_seen) begin
            in_frame <= 1'b1;
            mon_word <= 1;
        end else if (xgmii == idle_word) begin
            idle_run <= idle_run + 8;
        end
    end

    always @(posedge clk) begin : watch_end
        cycles <= cycles + 1;
        if (mon_frame == num_frames) begin
            finish_run();
        end else if (cycles >= cycle_limit) begin
            report_text($sformatf("timeout after %0d cycles with %0d frames seen",
                                  cycles, mon_frame));
            finish_run();
        end
    end

    assert property (@(posedge clk) reset_crc |=> (xgmii == idle_word))
        else report_value("xgmii", idle_word, $sampled(xgmii));

    assert property (@(posedge clk) reset_crc |=> !in_ready)
        else report_value("in_ready", 72'h0, {71'h0, $sampled(in_ready)});

    assert property (@(posedge clk) ($past(reset_crc) && !reset_crc) |=> in_ready)
        else report_value("in_ready", 72'h1, {71'h0, $sampled(in_ready)});

    assert property (@(posedge clk) disable iff (reset_crc)
        start_seen |-> (xgmii == start_word))
        else report_value("xgmii", start_word, $sampled(xgmii));

    assert property (@(posedge clk) disable iff (reset_crc)
        start_seen |-> (idle_run >= ifg_min))
        else report_text($sformatf("only %0d idle characters before a start",
                                   $sampled(idle_run)));

    assert property (@(posedge clk) disable iff (reset_crc)
        start_seen |-> !dropped)
        else report_text("start sent before the broken frame was drained");

    assert property (@(posedge clk) disable iff (reset_crc)
        in_frame |-> (xgmii == exp_word))
        else report_value("xgmii", $sampled(exp_word), $sampled(xgmii));

    assert property (@(posedge clk) disable iff (reset_crc)
        (!in_frame && !start_seen) |-> (xgmii == idle_word))
        else report_value("xgmii", idle_word, $sampled(xgmii));

endmodule

`default_nettype wire

// ==== build.f ====
design/eth_tx_pkg.sv
design/crc_byte_step.sv
design/tx_framer.sv
design/xgmii_encoder.sv
design/eth_tx_top.sv
tb/tb_clock.sv
tb/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the Ethernet transmitter testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top \
    -f build.f \
    -o sim_tb

sim_out=$(./obj_dir/sim_tb) || true
printf '%s\n' "$sim_out"

grep -qx 'All checks passed' <<< "$sim_out"
